/* bag_link.f */
bag_pkg.sv
dual_port_ram.sv
bag_framer.sv
bag_deframer.sv
bag_link.sv
tb_bag_link.sv

/* Makefile */
# Verilator build and run of the bag_link testbench.
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bag_link
FILELIST  ?= bag_link.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bag_link_input.txt */
# Columns: name kind device_idx data_idx stat param head data_len corrupt (all hex but name).
# corrupt is 0 for a clean frame, else the frame byte (sync is 1) whose bit 0 gets flipped.
ack_basic        1 3 5 a 00 00 000 0
nak_basic        2 f 0 1 ff ee 123 0
stall_basic      3 7 c 2 00 00 000 0
stall_all_ones   3 f f f 00 00 000 0
dlink_param      8 1 0 0 5a 00 000 0
dtype_param      9 2 4 4 c3 77 000 0
dtemp_param      a e 0 0 81 00 000 0
dtemp_zero       a 0 0 0 00 00 000 0
data0_len1       d 4 0 0 00 11 001 0
data0_len5       d 5 9 9 42 a5 005 0
data0_len80      d 6 0 0 00 3c 050 0
data0_len261     d 8 0 0 00 c0 105 0
bad_ack_body     1 3 5 a 00 00 000 3
bad_dlink_body   8 1 0 0 5a 00 000 3
bad_dtemp_csum   a e 0 0 81 00 000 4
bad_data0_head   d 5 0 0 00 a5 005 3
bad_data0_len    d 5 0 0 00 a5 005 4
ack_recovery     1 9 2 6 00 00 000 0
data0_after_bad  d 7 0 0 00 5e 00c 0

/* tb_bag_link.sv */
`default_nettype none

module tb_bag_link
    import bag_pkg::*;
();

    localparam int RISE_LIMIT = 10000;
    localparam int FALL_LIMIT = 3;
    localparam int HOLD_CYCLES = 5;

    logic clk;
    logic rst;
    ram_wr_t tx_wr;
    bag_header_t tx_hdr;
    logic tx_req;
    logic tx_ack;
    com_byte_t com_tx;
    com_byte_t com_rx;
    logic rx_req;
    logic rx_ack;
    bag_header_t rx_hdr;
    logic rx_crc_err;
    logic [BUF_ADDR_W-1:0] rx_rd_addr;
    logic [7:0] rx_rd_data;

    int err_count;
    int stray_count;
    int tests_run;
    int tests_passed;
    int tests_failed;
    int corrupt_pos;
    int loop_pos;
    com_byte_t loop_byte;
    bit frame_allowed;
    bit timed_out;
    bit file_error;
    logic [7:0] payload [$];

    bag_link UUT (
        .clk        (clk),
        .rst        (rst),
        .tx_wr      (tx_wr),
        .tx_hdr     (tx_hdr),
        .tx_req     (tx_req),
        .tx_ack     (tx_ack),
        .com_tx     (com_tx),
        .com_rx     (com_rx),
        .rx_req     (rx_req),
        .rx_ack     (rx_ack),
        .rx_hdr     (rx_hdr),
        .rx_crc_err (rx_crc_err),
        .rx_rd_addr (rx_rd_addr),
        .rx_rd_data (rx_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // The byte link loops back with one cycle of delay and an optional bit flip.
    initial begin
        com_rx <= '0;
        loop_pos = 0;
        forever begin
            @(negedge clk);
            if (com_tx.valid === 1'b1) begin
                loop_byte = com_tx;
                if ((corrupt_pos != 0) && (loop_pos + 1 == corrupt_pos)) begin
                    loop_byte.data[0] = ~loop_byte.data[0];
                end
                loop_pos = loop_pos + 1;
            end else begin
                loop_pos = 0;
                loop_byte = '0;
            end
            @(posedge clk);
            com_rx <= loop_byte;
        end
    end

    // The framer may only drive valid bytes between tx_req rising and tx_ack.
    initial begin
        stray_count = 0;
        forever begin
            @(negedge clk);
            if ((com_tx.valid === 1'b1) && (!frame_allowed || (tx_ack === 1'b1))) begin
                $display("error: com_tx.valid high at time %0t with no frame requested", $time);
                stray_count++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_header(input string what, input bag_header_t exp,
                                input bag_header_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", what, exp, act);
            err_count++;
        end
    endtask

    // Only the fields that the frame layout carries come back; the rest read zero.
    function automatic bag_header_t expected_header(input bag_header_t sent);
        bag_header_t exp;
        exp = '0;
        exp.kind = sent.kind;
        exp.device_idx = sent.device_idx;
        case (sent.kind)
            kind_ack, kind_nak, kind_stall: begin
                exp.data_idx = sent.data_idx;
                exp.device_stat = sent.device_stat;
            end
            kind_data0: begin
                exp.head = sent.head;
                exp.data_len = sent.data_len;
            end
            default: exp.param = sent.param;
        endcase
        return exp;
    endfunction

    task automatic wait_ack_rise(input bit rx_side, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && (cycles < RISE_LIMIT)) begin
            @(negedge clk);
            cycles++;
            if ((rx_side ? rx_ack : tx_ack) === 1'b1) begin
                ok = 1'b1;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One packet through the whole link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_test(input string tname, input bag_header_t hdr, input int corrupt);
        int errs_before;
        int i;
        int cycles;
        bit ok;
        bit tx_low;
        bit rx_low;
        logic [7:0] b;
        bag_header_t held_hdr;
        logic held_err;
        errs_before = err_count + stray_count;
        payload.delete();
        corrupt_pos = corrupt;
        if (hdr.kind == kind_data0) begin
            for (i = 0; i < int'(hdr.data_len); i++) begin
                b = 8'($urandom());
                payload.push_back(b);
                @(posedge clk);
                tx_wr <= '{en: 1'b1, addr: TX_BASE + BUF_ADDR_W'(i), data: b};
            end
            @(posedge clk);
            tx_wr <= '0;
        end
        @(posedge clk);
        tx_hdr <= hdr;
        rx_req <= 1'b1;
        @(posedge clk);
        tx_req <= 1'b1;
        frame_allowed = 1'b1;
        wait_ack_rise(1'b0, ok);
        if (!ok) begin
            $display("timeout: tx_ack did not rise within %0d cycles in test %s",
                     RISE_LIMIT, tname);
            timed_out = 1'b1;
        end else begin
            frame_allowed = 1'b0;
            wait_ack_rise(1'b1, ok);
            if (!ok) begin
                $display("timeout: rx_ack did not rise within %0d cycles in test %s",
                         RISE_LIMIT, tname);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            held_hdr = rx_hdr;
            held_err = rx_crc_err;
            if (corrupt != 0) begin
                check_flag({tname, " rx_crc_err"}, 1'b1, rx_crc_err);
            end else begin
                check_header({tname, " rx_hdr"}, expected_header(hdr), rx_hdr);
                check_flag({tname, " rx_crc_err"}, 1'b0, rx_crc_err);
            end
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_flag({tname, " tx_ack hold"}, 1'b1, tx_ack);
                check_flag({tname, " rx_ack hold"}, 1'b1, rx_ack);
                check_header({tname, " rx_hdr hold"}, held_hdr, rx_hdr);
                check_flag({tname, " rx_crc_err hold"}, held_err, rx_crc_err);
            end
            @(posedge clk);
            tx_req <= 1'b0;
            rx_req <= 1'b0;
            // Both acks must be low by the second edge after the reqs fall.
            tx_low = 1'b0;
            rx_low = 1'b0;
            cycles = 0;
            while (!(tx_low && rx_low) && (cycles < FALL_LIMIT)) begin
                @(negedge clk);
                cycles++;
                tx_low = tx_low || (tx_ack === 1'b0);
                rx_low = rx_low || (rx_ack === 1'b0);
            end
            if (!tx_low) begin
                $display("error: tx_ack still high two cycles after tx_req fell in test %s",
                         tname);
                err_count++;
            end
            if (!rx_low) begin
                $display("error: rx_ack still high two cycles after rx_req fell in test %s",
                         tname);
                err_count++;
            end
            if ((hdr.kind == kind_data0) && (corrupt == 0)) begin
                for (i = 0; i < payload.size(); i++) begin
                    @(posedge clk);
                    rx_rd_addr <= RX_BASE + BUF_ADDR_W'(i);
                    @(posedge clk);
                    @(negedge clk);
                    check_byte($sformatf("%s payload byte %0d", tname, i), payload[i],
                               rx_rd_data);
                end
            end
        end
        tests_run++;
        if ((err_count + stray_count == errs_before) && !timed_out) begin
            tests_passed++;
            $display("test %s: pass", tname);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", tname, err_count + stray_count - errs_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int fd;
        int n_fields;
        string line;
        string tname;
        logic [31:0] kind_v;
        logic [31:0] dev_v;
        logic [31:0] didx_v;
        logic [31:0] stat_v;
        logic [31:0] param_v;
        logic [31:0] head_v;
        logic [31:0] len_v;
        logic [31:0] corrupt_v;
        bag_header_t hdr_v;
        void'($urandom(32'hc67));
        err_count = 0;
        tests_run = 0;
        tests_passed = 0;
        tests_failed = 0;
        corrupt_pos = 0;
        frame_allowed = 1'b0;
        timed_out = 1'b0;
        file_error = 1'b0;
        rst <= 1'b1;
        tx_wr <= '0;
        tx_hdr <= '0;
        tx_req <= 1'b0;
        rx_req <= 1'b0;
        rx_rd_addr <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("reset tx_ack", 1'b0, tx_ack);
        check_flag("reset rx_ack", 1'b0, rx_ack);
        check_flag("reset com_tx.valid", 1'b0, com_tx.valid);
        $display("test reset_state: %s", (err_count == 0) ? "pass" : "fail");

        fd = $fopen("bag_link_input.txt", "r");
        if (fd == 0) begin
            $display("error: could not open bag_link_input.txt for reading");
            file_error = 1'b1;
        end else begin
            while (!timed_out && ($fgets(line, fd) != 0)) begin
                n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tname, kind_v, dev_v,
                                   didx_v, stat_v, param_v, head_v, len_v, corrupt_v);
                if ((line.len() > 0) && (line[0] != "#") && (n_fields == 9)) begin
                    hdr_v = '0;
                    hdr_v.kind = bag_kind_t'(kind_v[3:0]);
                    hdr_v.device_idx = dev_v[3:0];
                    hdr_v.data_idx = didx_v[3:0];
                    hdr_v.device_stat = stat_v[3:0];
                    hdr_v.param = param_v[7:0];
                    hdr_v.head = head_v[7:0];
                    hdr_v.data_len = len_v[11:0];
                    run_test(tname, hdr_v, int'(corrupt_v));
                end
            end
            $fclose(fd);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_passed, tests_failed, err_count + stray_count);
        if ((err_count + stray_count == 0) && !timed_out && !file_error && (tests_run > 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bag_link.sv */
`default_nettype none

module bag_link
    import bag_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire ram_wr_t           tx_wr,
    input  wire bag_header_t       tx_hdr,
    input  wire                    tx_req,
    output logic                   tx_ack,
    output com_byte_t              com_tx,
    input  wire com_byte_t         com_rx,
    input  wire                    rx_req,
    output logic                   rx_ack,
    output bag_header_t            rx_hdr,
    output logic                   rx_crc_err,
    input  wire [BUF_ADDR_W-1:0]   rx_rd_addr,
    output logic [7:0]             rx_rd_data
);

    logic [BUF_ADDR_W-1:0] tx_rd_addr;
    logic [7:0] tx_rd_data;
    ram_wr_t rx_wr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit side. Host fills tx_buf, framer drains it.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dual_port_ram tx_buf (
        .clk     (clk),
        .wr      (tx_wr),
        .rd_addr (tx_rd_addr),
        .rd_data (tx_rd_data)
    );

    bag_framer u_framer (
        .clk      (clk),
        .rst      (rst),
        .req      (tx_req),
        .ack      (tx_ack),
        .hdr      (tx_hdr),
        .ram_addr (tx_rd_addr),
        .ram_data (tx_rd_data),
        .com_tx   (com_tx)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive side. Deframer fills rx_buf, host reads it back.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bag_deframer u_deframer (
        .clk     (clk),
        .rst     (rst),
        .req     (rx_req),
        .ack     (rx_ack),
        .com_rx  (com_rx),
        .hdr     (rx_hdr),
        .crc_err (rx_crc_err),
        .ram_wr  (rx_wr)
    );

    dual_port_ram rx_buf (
        .clk     (clk),
        .wr      (rx_wr),
        .rd_addr (rx_rd_addr),
        .rd_data (rx_rd_data)
    );

endmodule

`default_nettype wire

/* bag_deframer.sv */
`default_nettype none

module bag_deframer
    import bag_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               req,
    output logic              ack,
    input  wire com_byte_t    com_rx,
    output bag_header_t       hdr,
    output logic              crc_err,
    output ram_wr_t           ram_wr
);

    typedef enum logic [3:0] {
        st_idle,
        st_hunt,
        st_kind,
        st_body,
        st_head,
        st_len_hi,
        st_len_lo,
        st_data,
        st_csum,
        st_ack
    } state_t;

    state_t state;
    logic [7:0] csum;
    logic [BUF_ADDR_W-1:0] remain;
    logic [BUF_ADDR_W-1:0] wr_addr;
    logic [BUF_ADDR_W-1:0] len_rx;
    logic in_frame;

    assign len_rx = {hdr.data_len[11:8], com_rx.data};
    assign in_frame = (state == st_kind) || (state == st_body) || (state == st_head) ||
                      (state == st_len_hi) || (state == st_len_lo) ||
                      (state == st_data) || (state == st_csum);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            ack     <= 1'b0;
            crc_err <= 1'b0;
            csum    <= 8'h00;
            remain  <= '0;
            wr_addr <= RX_BASE;
            ram_wr  <= '0;
            hdr     <= '0;
        end else begin
            ram_wr.en <= 1'b0;
            if (in_frame && !com_rx.valid) begin
                // The framer never leaves a gap inside a frame, so a gap means
                // the frame was cut short, for example by a corrupted length.
                crc_err <= 1'b1;
                ack     <= 1'b1;
                state   <= st_ack;
            end else begin
                if (in_frame && (state != st_csum)) begin
                    csum <= csum ^ com_rx.data;
                end
                case (state)
                    st_idle: begin
                        if (req) begin
                            state <= st_hunt;
                        end
                    end
                    st_hunt: begin
                        if (com_rx.valid && (com_rx.data == SYNC_BYTE)) begin
                            csum    <= 8'h00;
                            crc_err <= 1'b0;
                            hdr     <= '0;
                            state   <= st_kind;
                        end
                    end
                    st_kind: begin
                        hdr.kind       <= bag_kind_t'(com_rx.data[7:4]);
                        hdr.device_idx <= com_rx.data[3:0];
                        if (com_rx.data[7:4] == kind_data0) begin
                            state <= st_head;
                        end else begin
                            state <= st_body;
                        end
                    end
                    st_body: begin
                        if (body_is_status(hdr.kind)) begin
                            hdr.data_idx    <= com_rx.data[7:4];
                            hdr.device_stat <= com_rx.data[3:0];
                        end else begin
                            hdr.param <= com_rx.data;
                        end
                        state <= st_csum;
                    end
                    st_head: begin
                        hdr.head <= com_rx.data;
                        state    <= st_len_hi;
                    end
                    st_len_hi: begin
                        hdr.data_len[11:8] <= com_rx.data[3:0];
                        state              <= st_len_lo;
                    end
                    st_len_lo: begin
                        hdr.data_len[7:0] <= com_rx.data;
                        remain            <= len_rx;
                        wr_addr           <= RX_BASE;
                        state             <= (len_rx == '0) ? st_csum : st_data;
                    end
                    st_data: begin
                        ram_wr  <= '{en: 1'b1, addr: wr_addr, data: com_rx.data};
                        wr_addr <= wr_addr + 1'b1;
                        remain  <= remain - 1'b1;
                        if (remain == 12'd1) begin
                            state <= st_csum;
                        end
                    end
                    st_csum: begin
                        crc_err <= (csum != com_rx.data);
                        ack     <= 1'b1;
                        state   <= st_ack;
                    end
                    st_ack: begin
                        if (!req) begin
                            ack   <= 1'b0;
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* bag_framer.sv */
`default_nettype none

module bag_framer
    import bag_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req,
    output logic                   ack,
    input  wire bag_header_t       hdr,
    output logic [BUF_ADDR_W-1:0]  ram_addr,
    input  wire [7:0]              ram_data,
    output com_byte_t              com_tx
);

    typedef enum logic [3:0] {
        st_idle,
        st_prep,
        st_sync,
        st_kind,
        st_body,
        st_head,
        st_len_hi,
        st_len_lo,
        st_data,
        st_csum,
        st_ack
    } state_t;

    state_t state;
    state_t state_nxt;
    logic [7:0] tx_byte;
    logic tx_send;
    logic tx_fold;
    logic [7:0] csum;
    logic [BUF_ADDR_W-1:0] remain;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame walk. Each state picks the byte sent on its edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt = state;
        tx_byte   = 8'h00;
        tx_send   = 1'b0;
        tx_fold   = 1'b0;
        case (state)
            st_idle: begin
                if (req) begin
                    state_nxt = st_prep;
                end
            end
            st_prep: state_nxt = st_sync;
            st_sync: begin
                tx_byte   = SYNC_BYTE;
                tx_send   = 1'b1;
                state_nxt = st_kind;
            end
            st_kind: begin
                tx_byte   = {hdr.kind, hdr.device_idx};
                tx_send   = 1'b1;
                tx_fold   = 1'b1;
                state_nxt = (hdr.kind == kind_data0) ? st_head : st_body;
            end
            st_body: begin
                if (body_is_status(hdr.kind)) begin
                    tx_byte = {hdr.data_idx, hdr.device_stat};
                end else begin
                    tx_byte = hdr.param;
                end
                tx_send   = 1'b1;
                tx_fold   = 1'b1;
                state_nxt = st_csum;
            end
            st_head: begin
                tx_byte   = hdr.head;
                tx_send   = 1'b1;
                tx_fold   = 1'b1;
                state_nxt = st_len_hi;
            end
            st_len_hi: begin
                tx_byte   = {4'h0, hdr.data_len[11:8]};
                tx_send   = 1'b1;
                tx_fold   = 1'b1;
                state_nxt = st_len_lo;
            end
            st_len_lo: begin
                tx_byte   = hdr.data_len[7:0];
                tx_send   = 1'b1;
                tx_fold   = 1'b1;
                state_nxt = (hdr.data_len == '0) ? st_csum : st_data;
            end
            st_data: begin
                tx_byte = ram_data;
                tx_send = 1'b1;
                tx_fold = 1'b1;
                if (remain == 12'd1) begin
                    state_nxt = st_csum;
                end
            end
            st_csum: begin
                tx_byte   = csum;
                tx_send   = 1'b1;
                state_nxt = st_ack;
            end
            st_ack: begin
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // The read address runs one byte ahead of the payload being sent.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            ack      <= 1'b0;
            com_tx   <= '0;
            csum     <= 8'h00;
            remain   <= '0;
            ram_addr <= TX_BASE;
        end else begin
            state        <= state_nxt;
            ack          <= (state == st_ack);
            com_tx.valid <= tx_send;
            com_tx.data  <= tx_byte;
            if (state == st_prep) begin
                csum <= 8'h00;
            end else if (tx_fold) begin
                csum <= csum ^ tx_byte;
            end
            case (state)
                st_prep: begin
                    ram_addr <= TX_BASE;
                    remain   <= hdr.data_len;
                end
                st_len_lo: ram_addr <= ram_addr + 1'b1;
                st_data: begin
                    ram_addr <= ram_addr + 1'b1;
                    remain   <= remain - 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* dual_port_ram.sv */
`default_nettype none

module dual_port_ram
    import bag_pkg::*;
(
    input  wire                    clk,
    input  wire ram_wr_t           wr,
    input  wire [BUF_ADDR_W-1:0]   rd_addr,
    output logic [7:0]             rd_data
);

    logic [7:0] mem [BUF_DEPTH];

    // One write port and one read port on the same clock.
    // Read data shows up the cycle after the address.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* bag_pkg.sv */
`default_nettype none

package bag_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer geometry and frame constants.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int BUF_ADDR_W = 12;
    localparam int BUF_DEPTH = 4096;
    localparam logic [BUF_ADDR_W-1:0] TX_BASE = 12'h000;
    localparam logic [BUF_ADDR_W-1:0] RX_BASE = 12'h021;
    localparam logic [7:0] SYNC_BYTE = 8'h7e;

    typedef enum logic [3:0] {
        kind_ack   = 4'd1,
        kind_nak   = 4'd2,
        kind_stall = 4'd3,
        kind_dlink = 4'd8,
        kind_dtype = 4'd9,
        kind_dtemp = 4'd10,
        kind_data0 = 4'd13
    } bag_kind_t;

    typedef struct packed {
        bag_kind_t   kind;
        logic [3:0]  device_idx;
        logic [3:0]  data_idx;
        logic [3:0]  device_stat;
        logic [7:0]  param;
        logic [7:0]  head;
        logic [11:0] data_len;
    } bag_header_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } com_byte_t;

    typedef struct packed {
        logic                  en;
        logic [BUF_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } ram_wr_t;

    // Status packets carry index and status in their single body byte.
    function automatic logic body_is_status(bag_kind_t kind);
        return (kind == kind_ack) || (kind == kind_nak) || (kind == kind_stall);
    endfunction

endpackage

`default_nettype wire
